// File: logic/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  rob_tag_t;

    typedef enum logic [1:0] {
        CLASS_ALU    = 2'b00,
        CLASS_BRANCH = 2'b01,
        CLASS_MUL    = 2'b10
    } exec_class_e;

    // Low three bits follow funct3 and bit 3 marks the alternate forms
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    // Branch conditions keep their RISC-V funct3 codes
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        MUL_MUL    = 2'b00,
        MUL_MULH   = 2'b01,
        MUL_MULHSU = 2'b10,
        MUL_MULHU  = 2'b11
    } mul_op_e;

    // The operation class picks which view of the op field is meaningful
    typedef union packed {
        alu_op_e alu_op;
        struct packed {
            logic    spare;
            cmp_op_e cond;
        } cmp;
        struct packed {
            logic [1:0] spare;
            mul_op_e    kind;
        } mul;
    } exec_op_u;

endpackage

// File: logic/exec_issue_queue.sv
`timescale 1ns/1ps

module exec_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push_valid,
    input  exec_pkg::exec_class_e push_class,
    input  exec_pkg::exec_op_u    push_op,
    input  exec_pkg::rob_tag_t    push_tag,
    input  exec_pkg::word_t       push_pc,
    input  exec_pkg::word_t       push_rs1,
    input  exec_pkg::word_t       push_rs2,
    input  exec_pkg::word_t       push_imm,
    input  logic                  push_op1_pc,
    input  logic                  push_op2_imm,
    input  logic                  pop_stall,
    output logic                  pop_valid,
    output exec_pkg::exec_class_e pop_class,
    output exec_pkg::exec_op_u    pop_op,
    output exec_pkg::rob_tag_t    pop_tag,
    output exec_pkg::word_t       pop_pc,
    output exec_pkg::word_t       pop_rs1,
    output exec_pkg::word_t       pop_rs2,
    output exec_pkg::word_t       pop_imm,
    output logic                  pop_op1_pc,
    output logic                  pop_op2_imm,
    output logic                  credit_return
);
    import exec_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    exec_class_e      class_mem   [QUEUE_DEPTH];
    exec_op_u         op_mem      [QUEUE_DEPTH];
    rob_tag_t         tag_mem     [QUEUE_DEPTH];
    word_t            pc_mem      [QUEUE_DEPTH];
    word_t            rs1_mem     [QUEUE_DEPTH];
    word_t            rs2_mem     [QUEUE_DEPTH];
    word_t            imm_mem     [QUEUE_DEPTH];
    logic             op1_pc_mem  [QUEUE_DEPTH];
    logic             op2_imm_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             out_ready;
    logic             pop;

    // The output register takes a new entry when it is empty or its entry moves on
    assign out_ready     = !pop_valid || !pop_stall;
    assign pop           = (count != '0) && out_ready;
    assign credit_return = pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            if (push_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_valid) - CNT_W'(pop);
            if (out_ready) begin
                pop_valid <= pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid) begin
            class_mem[wr_ptr]   <= push_class;
            op_mem[wr_ptr]      <= push_op;
            tag_mem[wr_ptr]     <= push_tag;
            pc_mem[wr_ptr]      <= push_pc;
            rs1_mem[wr_ptr]     <= push_rs1;
            rs2_mem[wr_ptr]     <= push_rs2;
            imm_mem[wr_ptr]     <= push_imm;
            op1_pc_mem[wr_ptr]  <= push_op1_pc;
            op2_imm_mem[wr_ptr] <= push_op2_imm;
        end
        if (pop) begin
            pop_class   <= class_mem[rd_ptr];
            pop_op      <= op_mem[rd_ptr];
            pop_tag     <= tag_mem[rd_ptr];
            pop_pc      <= pc_mem[rd_ptr];
            pop_rs1     <= rs1_mem[rd_ptr];
            pop_rs2     <= rs2_mem[rd_ptr];
            pop_imm     <= imm_mem[rd_ptr];
            pop_op1_pc  <= op1_pc_mem[rd_ptr];
            pop_op2_imm <= op2_imm_mem[rd_ptr];
        end
    end

    // A full queue means the issuer has already spent every credit it was given
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push_valid |-> (count != CNT_W'(QUEUE_DEPTH))
    ) else $error("issue queue overflow");

endmodule

// File: logic/exec_operand_select.sv
`timescale 1ns/1ps

module exec_operand_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  exec_pkg::exec_class_e in_class,
    input  exec_pkg::exec_op_u    in_op,
    input  exec_pkg::rob_tag_t    in_tag,
    input  exec_pkg::word_t       in_pc,
    input  exec_pkg::word_t       in_rs1,
    input  exec_pkg::word_t       in_rs2,
    input  exec_pkg::word_t       in_imm,
    input  logic                  in_op1_pc,
    input  logic                  in_op2_imm,
    input  logic                  stall,
    output logic                  out_valid,
    output exec_pkg::exec_class_e out_class,
    output exec_pkg::exec_op_u    out_op,
    output exec_pkg::rob_tag_t    out_tag,
    output exec_pkg::word_t       alu_a,
    output exec_pkg::word_t       alu_b,
    output exec_pkg::word_t       cmp_a,
    output exec_pkg::word_t       cmp_b,
    output logic                  mul_start
);
    import exec_pkg::*;

    word_t sel_a;
    word_t sel_b;
    logic  mul_issued;

    always_comb begin
        if (in_class == CLASS_BRANCH) begin
            // The ALU forms the branch target while the comparator sees the registers
            sel_a = in_pc;
            sel_b = in_imm;
        end else begin
            sel_a = in_op1_pc ? in_pc : in_rs1;
            sel_b = in_op2_imm ? in_imm : in_rs2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            mul_issued <= 1'b0;
        end else if (!stall) begin
            out_valid  <= in_valid;
            mul_issued <= 1'b0;
        end else if (mul_start) begin
            mul_issued <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_class <= in_class;
            out_op    <= in_op;
            out_tag   <= in_tag;
            alu_a     <= sel_a;
            alu_b     <= sel_b;
            cmp_a     <= in_rs1;
            cmp_b     <= in_rs2;
        end
    end

    // One start per multiply, in its first cycle in the register
    assign mul_start = out_valid && (out_class == CLASS_MUL) && !mul_issued;

endmodule

// File: logic/exec_alu_cmp.sv
`timescale 1ns/1ps

module exec_alu_cmp (
    input  exec_pkg::exec_op_u    op,
    input  exec_pkg::exec_class_e op_class,
    input  exec_pkg::word_t       alu_a,
    input  exec_pkg::word_t       alu_b,
    input  exec_pkg::word_t       cmp_a,
    input  exec_pkg::word_t       cmp_b,
    output exec_pkg::word_t       alu_result,
    output logic                  branch_taken
);
    import exec_pkg::*;

    alu_op_e    alu_op;
    logic [4:0] shamt;
    logic       equal;
    logic       signed_lt;
    logic       unsigned_lt;
    logic       cond_true;

    // Branches reuse the adder for the target address
    assign alu_op = (op_class == CLASS_BRANCH) ? ALU_ADD : op.alu_op;
    assign shamt  = alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = alu_a + alu_b;
            ALU_SUB:    alu_result = alu_a - alu_b;
            ALU_SLL:    alu_result = alu_a << shamt;
            ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:    alu_result = alu_a ^ alu_b;
            ALU_SRL:    alu_result = alu_a >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(alu_a) >>> shamt);
            ALU_OR:     alu_result = alu_a | alu_b;
            ALU_AND:    alu_result = alu_a & alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    assign equal       = (cmp_a == cmp_b);
    assign signed_lt   = $signed(cmp_a) < $signed(cmp_b);
    assign unsigned_lt = (cmp_a < cmp_b);

    always_comb begin
        case (op.cmp.cond)
            CMP_BEQ:  cond_true = equal;
            CMP_BNE:  cond_true = !equal;
            CMP_BLT:  cond_true = signed_lt;
            CMP_BGE:  cond_true = !signed_lt;
            CMP_BLTU: cond_true = unsigned_lt;
            CMP_BGEU: cond_true = !unsigned_lt;
            default:  cond_true = 1'b0;
        endcase
    end

    // Taken only has meaning for branches
    assign branch_taken = (op_class == CLASS_BRANCH) && cond_true;

endmodule

// File: logic/exec_multiplier.sv
`timescale 1ns/1ps

module exec_multiplier (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  exec_pkg::mul_op_e mul_type,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    output exec_pkg::word_t   product,
    output logic              busy,
    output logic              done
);
    import exec_pkg::*;

    logic        a_signed;
    logic        b_signed;
    logic        a_neg;
    logic        b_neg;
    word_t       a_abs;
    word_t       b_abs;
    logic [63:0] acc;
    logic [63:0] mcand;
    logic [63:0] full;
    word_t       mplier;
    logic [4:0]  step;
    logic        neg;
    logic        high_word;

    // MUL keeps unsigned magnitudes since its low word ignores signedness
    assign a_signed = (mul_type == MUL_MULH) || (mul_type == MUL_MULHSU);
    assign b_signed = (mul_type == MUL_MULH);
    assign a_neg    = a_signed && a[31];
    assign b_neg    = b_signed && b[31];
    assign a_abs    = a_neg ? -a : a;
    assign b_abs    = b_neg ? -b : b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == 5'd31) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle with the multiplicand shifting left
    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= '0;
            mcand     <= {32'b0, a_abs};
            mplier    <= b_abs;
            neg       <= a_neg ^ b_neg;
            high_word <= (mul_type != MUL_MUL);
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign full    = neg ? -acc : acc;
    assign product = high_word ? full[63:32] : full[31:0];

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    ) else $error("multiplier started while busy");

endmodule

// File: logic/exec_writeback.sv
`timescale 1ns/1ps

module exec_writeback #(
    parameter int RESULT_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  exec_pkg::exec_class_e in_class,
    input  exec_pkg::rob_tag_t    in_tag,
    input  exec_pkg::word_t       alu_result,
    input  logic                  branch_taken,
    input  exec_pkg::word_t       mul_product,
    input  logic                  mul_busy,
    input  logic                  mul_done,
    input  logic                  result_credit,
    output logic                  lane_stall,
    output logic                  result_valid,
    output exec_pkg::rob_tag_t    result_tag,
    output exec_pkg::word_t       result_value,
    output logic                  result_taken
);
    import exec_pkg::*;

    localparam int CRED_W = $clog2(RESULT_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              res_full;
    logic              mul_held;
    logic              mul_ready;
    logic              send;
    logic              capture;

    // A finished product may wait here until the result register has room
    assign mul_ready    = mul_done || mul_held;
    assign send         = res_full && (credits != '0);
    assign capture      = in_valid && (!res_full || send) && ((in_class != CLASS_MUL) || mul_ready);
    assign lane_stall   = mul_busy || (in_valid && !capture);
    assign result_valid = send;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits  <= CRED_W'(RESULT_CREDITS);
            res_full <= 1'b0;
            mul_held <= 1'b0;
        end else begin
            credits <= credits - CRED_W'(send) + CRED_W'(result_credit);
            if (capture) begin
                res_full <= 1'b1;
            end else if (send) begin
                res_full <= 1'b0;
            end
            if (capture) begin
                mul_held <= 1'b0;
            end else if (mul_done) begin
                mul_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result_tag   <= in_tag;
            result_value <= (in_class == CLASS_MUL) ? mul_product : alu_result;
            result_taken <= branch_taken;
        end
    end

    // The consumer never hands back more credits than it was granted
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_credit |-> (credits != CRED_W'(RESULT_CREDITS)) || send
    ) else $error("result credit overflow");

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  exec_pkg::exec_class_e issue_class,
    input  exec_pkg::exec_op_u    issue_op,
    input  exec_pkg::rob_tag_t    issue_tag,
    input  exec_pkg::word_t       issue_pc,
    input  exec_pkg::word_t       issue_rs1,
    input  exec_pkg::word_t       issue_rs2,
    input  exec_pkg::word_t       issue_imm,
    input  logic                  issue_op1_pc,
    input  logic                  issue_op2_imm,
    output logic                  issue_credit,
    output logic                  result_valid,
    output exec_pkg::rob_tag_t    result_tag,
    output exec_pkg::word_t       result_value,
    output logic                  result_taken,
    input  logic                  result_credit
);
    import exec_pkg::*;

    logic        q_valid;
    exec_class_e q_class;
    exec_op_u    q_op;
    rob_tag_t    q_tag;
    word_t       q_pc;
    word_t       q_rs1;
    word_t       q_rs2;
    word_t       q_imm;
    logic        q_op1_pc;
    logic        q_op2_imm;
    logic        os_valid;
    exec_class_e os_class;
    exec_op_u    os_op;
    rob_tag_t    os_tag;
    word_t       alu_a;
    word_t       alu_b;
    word_t       cmp_a;
    word_t       cmp_b;
    logic        mul_start;
    word_t       alu_result;
    logic        branch_taken;
    word_t       mul_product;
    logic        mul_busy;
    logic        mul_done;
    logic        lane_stall;

    exec_issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk, .rst_n,
        .push_valid(issue_valid), .push_class(issue_class), .push_op(issue_op),
        .push_tag(issue_tag), .push_pc(issue_pc), .push_rs1(issue_rs1),
        .push_rs2(issue_rs2), .push_imm(issue_imm),
        .push_op1_pc(issue_op1_pc), .push_op2_imm(issue_op2_imm),
        .pop_stall(lane_stall),
        .pop_valid(q_valid), .pop_class(q_class), .pop_op(q_op), .pop_tag(q_tag),
        .pop_pc(q_pc), .pop_rs1(q_rs1), .pop_rs2(q_rs2), .pop_imm(q_imm),
        .pop_op1_pc(q_op1_pc), .pop_op2_imm(q_op2_imm),
        .credit_return(issue_credit)
    );

    exec_operand_select u_operands (
        .clk, .rst_n,
        .in_valid(q_valid), .in_class(q_class), .in_op(q_op), .in_tag(q_tag),
        .in_pc(q_pc), .in_rs1(q_rs1), .in_rs2(q_rs2), .in_imm(q_imm),
        .in_op1_pc(q_op1_pc), .in_op2_imm(q_op2_imm),
        .stall(lane_stall),
        .out_valid(os_valid), .out_class(os_class), .out_op(os_op), .out_tag(os_tag),
        .alu_a, .alu_b, .cmp_a, .cmp_b, .mul_start
    );

    exec_alu_cmp u_alu_cmp (
        .op(os_op), .op_class(os_class),
        .alu_a, .alu_b, .cmp_a, .cmp_b,
        .alu_result, .branch_taken
    );

    exec_multiplier u_mul (
        .clk, .rst_n,
        .start(mul_start), .mul_type(os_op.mul.kind), .a(alu_a), .b(alu_b),
        .product(mul_product), .busy(mul_busy), .done(mul_done)
    );

    exec_writeback #(.RESULT_CREDITS(RESULT_CREDITS)) u_writeback (
        .clk, .rst_n,
        .in_valid(os_valid), .in_class(os_class), .in_tag(os_tag),
        .alu_result, .branch_taken, .mul_product, .mul_busy, .mul_done,
        .result_credit, .lane_stall,
        .result_valid, .result_tag, .result_value, .result_taken
    );

endmodule

// File: test/exec_clock_gen.sv
`timescale 1ns/1ps

module exec_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release lands just after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

// File: test/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;
    import exec_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int RESULT_CREDITS = 2;
    localparam int CLK_PERIOD     = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int CYCLES_PER_OP  = 40;
    localparam int EXTRA_CYCLES   = 200;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    exec_class_e issue_class;
    exec_op_u    issue_op;
    rob_tag_t    issue_tag;
    word_t       issue_pc;
    word_t       issue_rs1;
    word_t       issue_rs2;
    word_t       issue_imm;
    logic        issue_op1_pc;
    logic        issue_op2_imm;
    logic        issue_credit;
    logic        result_valid;
    rob_tag_t    result_tag;
    word_t       result_value;
    logic        result_taken;
    logic        result_credit;

    // Trace columns, one entry per operation
    logic [1:0]  tr_class   [$];
    logic [3:0]  tr_op      [$];
    rob_tag_t    tr_tag     [$];
    word_t       tr_pc      [$];
    word_t       tr_rs1     [$];
    word_t       tr_rs2     [$];
    word_t       tr_imm     [$];
    logic        tr_op1_pc  [$];
    logic        tr_op2_imm [$];
    word_t       tr_value   [$];
    logic        tr_taken   [$];

    // Trace indices of issued operations whose results are still owed, oldest first
    int          outstanding [$];

    int          trace_len;
    bit          trace_loaded;
    int          next_op;
    int          results_seen;
    int          issue_credits;
    int          dut_credits;
    logic [31:0] lfsr;

    exec_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (.clk, .rst_n);

    exec_unit #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESULT_CREDITS(RESULT_CREDITS)) UUT (
        .clk, .rst_n,
        .issue_valid, .issue_class, .issue_op, .issue_tag,
        .issue_pc, .issue_rs1, .issue_rs2, .issue_imm,
        .issue_op1_pc, .issue_op2_imm, .issue_credit,
        .result_valid, .result_tag, .result_value, .result_taken,
        .result_credit
    );

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input int op_index);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED result_value: got %h, expected %h (trace op %0d)",
                                        actual, expected, op_index));
        end
    endtask

    task automatic check_tag(input rob_tag_t actual, input rob_tag_t expected, input int op_index);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED result_tag: got %h, expected %h (trace op %0d)",
                                        actual, expected, op_index));
        end
    endtask

    task automatic check_taken(input logic actual, input logic expected, input int op_index);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED result_taken: got %h, expected %h (trace op %0d)",
                                        actual, expected, op_index));
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f [11];
        fd = $fopen("test/exec_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the trace file test/exec_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4], f[5],
                                     f[6], f[7], f[8], f[9], f[10]);
                    if (fields != 11) begin
                        stop_with_failure($sformatf("Malformed trace line: %s", line));
                    end else begin
                        tr_class.push_back(f[0][1:0]);
                        tr_op.push_back(f[1][3:0]);
                        tr_tag.push_back(f[2][3:0]);
                        tr_pc.push_back(f[3]);
                        tr_rs1.push_back(f[4]);
                        tr_rs2.push_back(f[5]);
                        tr_imm.push_back(f[6]);
                        tr_op1_pc.push_back(f[7][0]);
                        tr_op2_imm.push_back(f[8][0]);
                        tr_value.push_back(f[9]);
                        tr_taken.push_back(f[10][0]);
                    end
                end
            end
            $fclose(fd);
            trace_len = tr_class.size();
        end
    endtask

    // One clock of stimulus, applied shortly after the rising edge
    task automatic drive_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        issue_valid = 1'b0;
        if (next_op < trace_len && issue_credits > 0) begin
            issue_valid   = 1'b1;
            issue_class   = exec_class_e'(tr_class[next_op]);
            issue_op      = exec_op_u'(tr_op[next_op]);
            issue_tag     = tr_tag[next_op];
            issue_pc      = tr_pc[next_op];
            issue_rs1     = tr_rs1[next_op];
            issue_rs2     = tr_rs2[next_op];
            issue_imm     = tr_imm[next_op];
            issue_op1_pc  = tr_op1_pc[next_op];
            issue_op2_imm = tr_op2_imm[next_op];
            outstanding.push_back(next_op);
            issue_credits = issue_credits - 1;
            next_op       = next_op + 1;
        end
        // The consumer only returns credits that the DUT has spent
        result_credit = 1'b0;
        if (dut_credits < RESULT_CREDITS) begin
            lfsr          = lfsr_step(lfsr);
            result_credit = lfsr[0];
        end
    endtask

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin : monitor
        int idx;
        if (issue_credit === 1'b1) begin
            issue_credits = issue_credits + 1;
            if (issue_credits > QUEUE_DEPTH) begin
                stop_with_failure("An issue credit came back for an operation never issued");
            end
        end
        if (result_valid === 1'b1) begin
            if (dut_credits == 0) begin
                stop_with_failure("A result was sent while the DUT held no result credit");
            end else if (outstanding.size() == 0) begin
                stop_with_failure("A result arrived with no operation outstanding");
            end else begin
                idx = outstanding.pop_front();
                check_tag(result_tag, tr_tag[idx], idx);
                check_value(result_value, tr_value[idx], idx);
                check_taken(result_taken, tr_taken[idx], idx);
                results_seen = results_seen + 1;
            end
            dut_credits = dut_credits - 1;
        end
        if (result_credit === 1'b1) begin
            dut_credits = dut_credits + 1;
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        #((trace_len * CYCLES_PER_OP + EXTRA_CYCLES) * CLK_PERIOD);
        stop_with_failure("Timeout: the DUT did not return every result in time");
    end

    initial begin : stimulus
        issue_valid   = 1'b0;
        issue_class   = CLASS_ALU;
        issue_op      = '0;
        issue_tag     = '0;
        issue_pc      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_imm     = '0;
        issue_op1_pc  = 1'b0;
        issue_op2_imm = 1'b0;
        result_credit = 1'b0;
        next_op       = 0;
        results_seen  = 0;
        issue_credits = QUEUE_DEPTH;
        dut_credits   = RESULT_CREDITS;
        lfsr          = 32'h4e378536;
        trace_loaded  = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        wait (rst_n === 1'b1);
        while (next_op < trace_len || results_seen < trace_len) begin
            drive_cycle();
        end
        // Keep credits flowing a while so that a duplicated result would still show up
        repeat (16) drive_cycle();
        if (issue_credits == QUEUE_DEPTH && outstanding.size() == 0
                && results_seen == trace_len) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_with_failure($sformatf(
                "Run ended with %0d of %0d issue credits and %0d of %0d results",
                issue_credits, QUEUE_DEPTH, results_seen, trace_len));
        end
    end

endmodule

// File: test/exec_trace.txt
# class op tag pc rs1 rs2 imm op1_pc op2_imm expected_value expected_taken (all hex)
# class 0 ALU, 1 branch, 2 multiply; op is the ALU op, branch funct3 or multiply type
0 0 0 00001000 00000005 00000007 00000000 0 0 0000000c 0
0 0 1 00001000 deadbeef 12345678 00000010 1 1 00001010 0
0 8 2 00001008 00000003 00000005 00000000 0 0 fffffffe 0
0 1 3 0000100c 00000001 00000000 0000001f 0 1 80000000 0
0 2 4 00001010 ffffffff 00000001 00000000 0 0 00000001 0
0 3 5 00001014 ffffffff 00000001 00000000 0 0 00000000 0
0 4 6 00001018 f0f0f0f0 00000000 ffffffff 0 1 0f0f0f0f 0
0 5 7 0000101c 80000000 00000004 00000000 0 0 08000000 0
0 d 8 00001020 80000000 00000004 00000000 0 0 f8000000 0
0 7 9 00001024 12345678 00000000 0000ff00 0 1 00005600 0
0 f a 00001028 11111111 22222222 abcde000 0 1 abcde000 0
1 0 b 00002000 00000005 00000005 00000040 0 0 00002040 1
1 1 c 00002004 00000005 00000005 fffffff0 0 0 00001ff4 0
1 4 d 00002008 80000000 7fffffff 00000100 0 0 00002108 1
1 6 e 0000200c 80000000 7fffffff 00000008 0 0 00002014 0
1 5 f 00002010 ffffffff ffffffff fffffffc 1 1 0000200c 1
1 7 0 00002014 00000000 ffffffff 00000020 0 0 00002034 0
2 0 1 00003000 00000007 fffffffd 00000000 0 0 ffffffeb 0
2 1 2 00003004 80000000 80000000 00000000 0 0 40000000 0
2 2 3 00003008 ffffffff ffffffff 00000000 0 0 ffffffff 0
2 3 4 0000300c ffffffff ffffffff 00000000 0 0 fffffffe 0
0 0 5 00003010 00000100 00000000 00000023 0 1 00000123 0
2 1 6 00003014 00012345 ffff0000 00000000 0 0 fffffffe 0
2 0 7 00003018 fffffffe fffffffd 00000000 0 0 00000006 0
1 1 8 0000301c 00000001 00000002 00000010 0 0 0000302c 1
0 8 9 00003020 00000000 00000001 00000000 0 0 ffffffff 0

// File: compile.f
logic/exec_pkg.sv
logic/exec_issue_queue.sv
logic/exec_operand_select.sv
logic/exec_alu_cmp.sv
logic/exec_multiplier.sv
logic/exec_writeback.sv
logic/exec_unit.sv
test/exec_clock_gen.sv
test/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/exec_issue_queue.sv
      - logic/exec_operand_select.sv
      - logic/exec_alu_cmp.sv
      - logic/exec_multiplier.sv
      - logic/exec_writeback.sv
      - logic/exec_unit.sv
  - target: test
    files:
      - test/exec_clock_gen.sv
      - test/exec_unit_tb.sv
